//--- Makefile
# Verilator build and run for the game ROM access testbench
VERILATOR ?= verilator
TOP       ?= tb_game_rom
SEED_ARGS ?= +verilator+seed+1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

VFLAGS = --binary --timing --assert -f build.f --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+.
sdram_pkg.sv
rom_slot_pkg.sv
rom_slot_cache.sv
rom_arbiter.sv
rom_bank.sv
ioctl_dwnld.sv
game_rom_top.sv
tb_sdram_model.sv
tb_game_rom.sv

//--- game_macros.svh
/* SDRAM memory map of the game ROMs. Start values are byte addresses.
   Slot offsets in SDRAM words are these values halved */
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// SDRAM word address width
`define SDRAM_AW  22

// Client address widths
`define GFX1_AW   18    // 16-bit words
`define PCM_AW    17    // Bytes
`define SND_AW    15    // Bytes
`define MAIN_AW   18    // Bytes

// Main code sits at byte 0
`define SND_START 25'h040000
`define PCM_START 25'h048000
`define GFX_START 25'h068000

`endif

//--- game_rom_top.sv
/* ROM access part of the game core. Reads and download writes share
   sdram_ack, so the SDRAM controller answers whichever side is requesting.
   No read should be in flight when downloading rises */
`include "game_macros.svh"

module game_rom_top (
    input                        clk,
    input                        rst_n,
    input                        downloading,
    // Loader
    input        [24:0]          ioctl_addr,
    input        [7:0]           ioctl_dout,
    input                        ioctl_wr,
    output sdram_pkg::prog_wr_t  prog,
    output logic                 prog_we,
    // ROM clients
    input                        gfx1_cs,
    input        [`GFX1_AW-1:0]  gfx1_addr,
    output logic                 gfx1_ok,
    output logic [15:0]          gfx1_data,
    input                        pcm_cs,
    input        [`PCM_AW-1:0]   pcm_addr,
    output logic                 pcm_ok,
    output logic [7:0]           pcm_data,
    input                        snd_cs,
    input        [`SND_AW-1:0]   snd_addr,
    output logic                 snd_ok,
    output logic [7:0]           snd_data,
    input                        main_cs,
    input        [`MAIN_AW-1:0]  main_addr,
    output logic                 main_ok,
    output logic [7:0]           main_data,
    // SDRAM
    output logic                 sdram_req,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    input                        sdram_ack,
    input                        data_rdy,
    input        [15:0]          data_read
);

    ioctl_dwnld u_dwnld (
        .clk, .rst_n, .downloading,
        .ioctl_addr, .ioctl_dout, .ioctl_wr,
        .sdram_ack, .prog, .prog_we
    );

    rom_bank u_bank (
        .clk, .rst_n, .downloading,
        .gfx1_cs, .gfx1_addr, .gfx1_ok, .gfx1_data,
        .pcm_cs, .pcm_addr, .pcm_ok, .pcm_data,
        .snd_cs, .snd_addr, .snd_ok, .snd_data,
        .main_cs, .main_addr, .main_ok, .main_data,
        .sdram_req, .sdram_addr, .sdram_ack, .data_rdy, .data_read
    );

endmodule

//--- ioctl_dwnld.sv
/* Turns loader bytes into masked SDRAM word writes. The loader must not
   strobe ioctl_wr again before sdram_ack. Byte address bits above the
   SDRAM range are ignored */
`include "game_macros.svh"

module ioctl_dwnld (
    input                       clk,
    input                       rst_n,
    input                       downloading,
    input        [24:0]         ioctl_addr,
    input        [7:0]          ioctl_dout,
    input                       ioctl_wr,
    input                       sdram_ack,
    output sdram_pkg::prog_wr_t prog,
    output logic                prog_we
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (ioctl_wr && downloading) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;                            // Write taken
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            prog.addr <= ioctl_addr[`SDRAM_AW:1];
            prog.data <= ioctl_dout;
            prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;  // Odd byte to high lane
        end
    end

    // A strobe in the ack cycle itself is still safe
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && !sdram_ack |-> !ioctl_wr);

endmodule

//--- rom_arbiter.sv
/* Fixed-priority sequencer for the SDRAM read port. Only one read is in
   flight, and GFX1 wins over PCM, SND and MAIN. Nothing new is granted
   while downloading, though a read already issued still completes */
`include "game_macros.svh"

module rom_arbiter (
    input                                     clk,
    input                                     rst_n,
    input                                     downloading,
    input  rom_slot_pkg::slot_req_t           req [rom_slot_pkg::slot_num],
    input                                     sdram_ack,
    input                                     data_rdy,
    input        [15:0]                       data_read,
    output logic [rom_slot_pkg::slot_num-1:0] rdy,
    output sdram_pkg::sdram_word_u            data,
    output logic                              sdram_req,
    output logic [`SDRAM_AW-1:0]              sdram_addr
);
    import rom_slot_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } arb_st_e;

    arb_st_e  st;
    slot_id_e winner;
    slot_id_e granted;
    logic     any_req;

    // Lowest id wins
    // A slot that sees its rdy this cycle still shows its old request
    always_comb begin
        winner  = GFX1;
        any_req = 1'b0;
        for (int i = slot_num - 1; i >= 0; i--) begin
            if (req[i].req && !rdy[i]) begin
                winner  = slot_id_e'(i);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st        <= IDLE;
            granted   <= GFX1;
            sdram_req <= 1'b0;
            rdy       <= '0;
        end else begin
            rdy <= '0;
            case (st)
                IDLE: begin
                    if (any_req && !downloading) begin
                        granted   <= winner;
                        sdram_req <= 1'b1;
                        st        <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        st        <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_rdy) begin
                        rdy[granted] <= 1'b1;           // Strobe with the data
                        st           <= IDLE;
                    end
                end
                default: st <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == IDLE) begin
            sdram_addr <= req[winner].addr;
        end
        if (st == WAIT_DATA && data_rdy) begin
            data <= data_read;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr));

    a_no_req_dwnld: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> !$past(downloading));

    // The strobed slot must still be waiting for its word
    a_rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rdy) && (rdy == '0 || req[granted].req));

endmodule

//--- rom_bank.sv
/* Four ROM slots sharing one SDRAM read port.
   Region offsets come from the memory map macros */
`include "game_macros.svh"

module rom_bank (
    input                        clk,
    input                        rst_n,
    input                        downloading,
    input                        gfx1_cs,
    input        [`GFX1_AW-1:0]  gfx1_addr,
    output logic                 gfx1_ok,
    output logic [15:0]          gfx1_data,
    input                        pcm_cs,
    input        [`PCM_AW-1:0]   pcm_addr,
    output logic                 pcm_ok,
    output logic [7:0]           pcm_data,
    input                        snd_cs,
    input        [`SND_AW-1:0]   snd_addr,
    output logic                 snd_ok,
    output logic [7:0]           snd_data,
    input                        main_cs,
    input        [`MAIN_AW-1:0]  main_addr,
    output logic                 main_ok,
    output logic [7:0]           main_data,
    output logic                 sdram_req,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    input                        sdram_ack,
    input                        data_rdy,
    input        [15:0]          data_read
);
    import sdram_pkg::*;
    import rom_slot_pkg::*;

    // Word offsets
    localparam int unsigned GFX1_OFFSET = `GFX_START >> 1;
    localparam int unsigned PCM_OFFSET  = `PCM_START >> 1;
    localparam int unsigned SND_OFFSET  = `SND_START >> 1;

    slot_req_t           req [slot_num];    // Indexed by slot_id_e
    logic [slot_num-1:0] rdy;
    sdram_word_u         data;

    rom_slot_cache #(.AW(`GFX1_AW), .DW(16), .OFFSET(GFX1_OFFSET)) u_gfx1 (
        .clk, .rst_n, .downloading, .data,
        .cs(gfx1_cs), .addr(gfx1_addr), .ok(gfx1_ok), .dout(gfx1_data),
        .rdy(rdy[GFX1]), .req(req[GFX1])
    );

    rom_slot_cache #(.AW(`PCM_AW), .DW(8), .OFFSET(PCM_OFFSET)) u_pcm (
        .clk, .rst_n, .downloading, .data,
        .cs(pcm_cs), .addr(pcm_addr), .ok(pcm_ok), .dout(pcm_data),
        .rdy(rdy[PCM]), .req(req[PCM])
    );

    rom_slot_cache #(.AW(`SND_AW), .DW(8), .OFFSET(SND_OFFSET)) u_snd (
        .clk, .rst_n, .downloading, .data,
        .cs(snd_cs), .addr(snd_addr), .ok(snd_ok), .dout(snd_data),
        .rdy(rdy[SND]), .req(req[SND])
    );

    rom_slot_cache #(.AW(`MAIN_AW), .DW(8), .OFFSET(0)) u_main (
        .clk, .rst_n, .downloading, .data,
        .cs(main_cs), .addr(main_addr), .ok(main_ok), .dout(main_data),
        .rdy(rdy[MAIN]), .req(req[MAIN])
    );

    rom_arbiter u_arb (
        .clk, .rst_n, .downloading, .req, .rdy, .data,
        .sdram_ack, .data_rdy, .data_read, .sdram_req, .sdram_addr
    );

endmodule

//--- rom_slot_cache.sv
/* One ROM slot with a single cached SDRAM word. DW is 8 or 16.
   The client holds cs and addr until ok. 8-bit slots read the high byte
   when addr[0] is set. The cached word is dropped while downloading */
`include "game_macros.svh"

module rom_slot_cache #(
    parameter int          AW     = 18,
    parameter int          DW     = 8,
    parameter int unsigned OFFSET = 0
) (
    input                           clk,
    input                           rst_n,
    input                           downloading,
    input                           cs,
    input        [AW-1:0]           addr,
    input                           rdy,
    input  sdram_pkg::sdram_word_u  data,
    output logic                    ok,
    output logic [DW-1:0]           dout,
    output rom_slot_pkg::slot_req_t req
);
    import sdram_pkg::*;

    localparam int WAW = `SDRAM_AW;

    logic [WAW-1:0] word_addr;
    logic [WAW-1:0] cached_addr;
    logic [WAW-1:0] pend_addr;
    logic           valid;
    logic           pend;
    logic           hit;
    logic           fill;
    sdram_word_u    cached;
    sdram_word_u    src;
    logic [DW-1:0]  dout_nx;

    generate
        if (DW == 16) begin : g_word
            assign word_addr = WAW'(OFFSET) + WAW'(addr);
            assign dout_nx   = src.word;
        end else begin : g_byte
            assign word_addr = WAW'(OFFSET) + WAW'(addr[AW-1:1]);
            assign dout_nx   = addr[0] ? src.bytes.hi : src.bytes.lo;
        end
    endgenerate

    assign hit      = valid && cached_addr == word_addr;
    assign fill     = rdy && pend_addr == word_addr;   // Fetched word is the one asked
    assign src      = rdy ? data : cached;
    assign req.req  = pend;
    assign req.addr = pend_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            pend  <= 1'b0;
            ok    <= 1'b0;
        end else begin
            ok <= cs && !downloading && (hit || fill);
            if (downloading) begin
                valid <= 1'b0;
            end else if (rdy) begin
                valid <= 1'b1;
            end
            if (rdy) begin
                pend <= 1'b0;
            end else if (cs && !hit && !pend && !downloading) begin
                pend <= 1'b1;                           // Miss goes to the arbiter
            end
        end
    end

    always_ff @(posedge clk) begin
        dout <= dout_nx;
        if (rdy) begin
            cached      <= data;
            cached_addr <= pend_addr;
        end
        if (!pend) begin
            pend_addr <= word_addr;                     // Frozen while requesting
        end
    end

    // ok only for a cs whose word now sits in the cache
    a_ok_after_cs: assert property (@(posedge clk) disable iff (!rst_n)
        ok |-> $past(cs) && valid && cached_addr == $past(word_addr));

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        req.req && !rdy |=> req.req && $stable(req.addr));

endmodule

//--- rom_slot_pkg.sv
/* Client side types of the ROM slots.
   The enum order is the arbiter priority, GFX1 first */
`include "game_macros.svh"

package rom_slot_pkg;

    typedef enum logic [1:0] {
        GFX1 = 2'd0,
        PCM  = 2'd1,
        SND  = 2'd2,
        MAIN = 2'd3
    } slot_id_e;

    localparam int slot_num = 4;

    // Cache miss request towards the arbiter
    typedef struct packed {
        logic                 req;
        logic [`SDRAM_AW-1:0] addr;     // SDRAM word address
    } slot_req_t;

endpackage

//--- sdram_pkg.sv
/* SDRAM side types. Words are 16 bits wide.
   The low byte holds the even ROM byte and the high byte the odd one */
`include "game_macros.svh"

package sdram_pkg;

    typedef struct packed {
        logic [7:0] hi;     // Odd byte
        logic [7:0] lo;     // Even byte
    } sdram_bytes_t;

    // 16-bit slots take the word, 8-bit slots pick a byte
    typedef union packed {
        logic [15:0]  word;
        sdram_bytes_t bytes;
    } sdram_word_u;

    // One download write to SDRAM
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;     // Word address
        logic [7:0]           data;
        logic [1:0]           mask;     // Active low, bit 0 is the low byte
    } prog_wr_t;

endpackage

//--- tb_game_rom.sv
/* Testbench for game_rom_top. Slot index 0..3 is GFX1, PCM, SND, MAIN.
   Expected data comes from the fill pattern and the bytes loaded through ioctl */
`include "game_macros.svh"

module tb_game_rom;
    import sdram_pkg::*;

    localparam int unsigned SEED = 32'h7a191623;
    localparam int N_RAND    = 16;                  // Random reads per slot
    localparam int HIT_LAT   = 2;                   // cs seen one edge after it is driven
    localparam int WORST_LAT = 48;                  // Four slots queued behind slow SDRAM
    localparam int N_TRANS   = 8 * N_RAND + 16;
    localparam int TIMEOUT   = (N_TRANS * WORST_LAT + 200) * 8;

    logic                 clk;
    logic                 rst_n;
    logic                 downloading;
    logic [24:0]          ioctl_addr;
    logic [7:0]           ioctl_dout;
    logic                 ioctl_wr;
    prog_wr_t             prog;
    logic                 prog_we;
    logic                 cs [4];
    logic [17:0]          addr [4];                 // Wide enough for every slot
    logic                 ok [4];
    logic [15:0]          dout [4];
    logic [7:0]           pcm_data;
    logic [7:0]           snd_data;
    logic [7:0]           main_data;
    logic                 sdram_req;
    logic [`SDRAM_AW-1:0] sdram_addr;
    logic                 sdram_ack;
    logic                 data_rdy;
    logic [15:0]          data_read;
    logic [15:0]          written [logic [`SDRAM_AW-1:0]];
    logic [`SDRAM_AW-1:0] req_addrs [$];            // Address of every sdram_req rise
    logic [17:0]          seen_addr [4];
    logic                 prev_req;
    int                   errors;
    int                   checks;

    assign dout[1] = {8'h00, pcm_data};
    assign dout[2] = {8'h00, snd_data};
    assign dout[3] = {8'h00, main_data};

    game_rom_top game_rom_top_i (
        .clk, .rst_n, .downloading, .ioctl_addr, .ioctl_dout, .ioctl_wr, .prog, .prog_we,
        .gfx1_cs(cs[0]), .gfx1_addr(addr[0]), .gfx1_ok(ok[0]), .gfx1_data(dout[0]),
        .pcm_cs(cs[1]), .pcm_addr(addr[1][16:0]), .pcm_ok(ok[1]), .pcm_data,
        .snd_cs(cs[2]), .snd_addr(addr[2][14:0]), .snd_ok(ok[2]), .snd_data,
        .main_cs(cs[3]), .main_addr(addr[3]), .main_ok(ok[3]), .main_data,
        .sdram_req, .sdram_addr, .sdram_ack, .data_rdy, .data_read
    );

    tb_sdram_model #(.SEED(SEED)) u_sdram (
        .clk, .rst_n, .sdram_req, .sdram_addr, .prog_we, .prog,
        .sdram_ack, .data_rdy, .data_read
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] fill_word(input logic [`SDRAM_AW-1:0] a);
        return 16'(a * 22'h2f5b) ^ a[`SDRAM_AW-1:6];
    endfunction

    // SDRAM word that a slot address lands on
    function automatic logic [`SDRAM_AW-1:0] word_of(input int s, input logic [17:0] a);
        case (s)
            0:       return 22'(`GFX_START / 2) + 22'(a);
            1:       return 22'(`PCM_START / 2) + 22'(a[17:1]);
            2:       return 22'(`SND_START / 2) + 22'(a[17:1]);
            default: return 22'(a[17:1]);
        endcase
    endfunction

    // Reference model of slot data
    function automatic logic [15:0] expected(input int s, input logic [17:0] a);
        logic [`SDRAM_AW-1:0] w;
        logic [15:0]          d;
        w = word_of(s, a);
        d = written.exists(w) ? written[w] : fill_word(w);
        if (s == 0) return d;
        return a[0] ? {8'h00, d[15:8]} : {8'h00, d[7:0]};   // Odd byte is the high one
    endfunction

    function automatic logic [17:0] rand_addr(input int s);
        logic [17:0] a;
        a = 18'($urandom);
        case (s)
            1:       a[17] = 1'b0;
            2:       a[17:15] = 3'b000;
            default: ;
        endcase
        return a;
    endfunction

    task automatic read_slot(input int s, input logic [17:0] a, output int lat);
        @(posedge clk);
        cs[s]   <= 1'b1;
        addr[s] <= a;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!ok[s]);
        cs[s] <= 1'b0;
    endtask

    task automatic load_byte(input logic [24:0] ba, input logic [7:0] d);
        logic [15:0] wv;
        @(posedge clk);
        ioctl_addr <= ba;
        ioctl_dout <= d;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(posedge clk);                             // prog_we due one clock after ioctl_wr
        if (!prog_we) begin
            errors++;
            $display("FAIL %0t: prog_we missing after ioctl_wr to %h", $time, ba);
        end
        while (prog_we && !sdram_ack) @(posedge clk);
        if (!prog_we || prog.addr != ba[`SDRAM_AW:1] || prog.data != d
                || prog.mask != (ba[0] ? 2'b01 : 2'b10)) begin
            errors++;
            $display("FAIL %0t: prog write for byte %h is %h, we %b at ack", $time, ba, prog,
                     prog_we);
        end
        wv = written.exists(ba[`SDRAM_AW:1]) ? written[ba[`SDRAM_AW:1]]
                                            : fill_word(ba[`SDRAM_AW:1]);
        if (ba[0]) wv[15:8] = d;
        else wv[7:0] = d;
        written[ba[`SDRAM_AW:1]] = wv;
    endtask

    // ok and dout were registered from the address seen one edge earlier
    always @(posedge clk) begin
        if (!rst_n) begin
            prev_req = 1'b0;
        end else begin
            for (int s = 0; s < 4; s++) begin
                if (ok[s]) begin
                    checks++;
                    if (dout[s] != expected(s, seen_addr[s])) begin
                        errors++;
                        $display("FAIL %0t: slot %0d addr %h gave %h, expected %h", $time, s,
                                 seen_addr[s], dout[s], expected(s, seen_addr[s]));
                    end
                end
                seen_addr[s] = addr[s];
            end
            if (sdram_req && !prev_req) req_addrs.push_back(sdram_addr);
            prev_req = sdram_req;
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired, the run did not finish in %0d time units", TIMEOUT);
        $display("Errors: %0d, checks: %0d", errors, checks);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [17:0] a;
        logic [17:0] da [4];
        int          lat;
        int          lats [4];
        int          n;
        void'($urandom(SEED));
        clk = 1'b0;
        rst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr = 1'b0;
        for (int s = 0; s < 4; s++) begin
            cs[s] = 1'b0;
            addr[s] = '0;
        end
        errors = 0;
        checks = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        if (sdram_req || prog_we || ok[0] || ok[1] || ok[2] || ok[3]) begin
            errors++;
            $display("FAIL %0t: outputs not idle after reset", $time);
        end

        // Miss then hit on the same word or on its other byte
        for (int i = 0; i < N_RAND; i++) begin
            for (int s = 0; s < 4; s++) begin
                a = rand_addr(s);
                read_slot(s, a, lat);
                n = req_addrs.size();
                read_slot(s, s == 0 ? a : a ^ 18'd1, lat);
                repeat (2) @(posedge clk);
                if (lat != HIT_LAT || req_addrs.size() != n) begin
                    errors++;
                    $display("FAIL %0t: slot %0d repeat read took %0d cycles, %0d new requests",
                             $time, s, lat, req_addrs.size() - n);
                end
            end
        end

        // Cache a word per slot and overwrite it through the loader
        for (int s = 0; s < 4; s++) begin
            da[s] = rand_addr(s);
            read_slot(s, da[s], lat);
        end
        @(posedge clk);
        downloading <= 1'b1;
        for (int s = 0; s < 4; s++) begin
            for (int b = 0; b < 2; b++) begin
                load_byte({2'b00, word_of(s, da[s]), b[0]}, 8'($urandom));
            end
        end
        @(posedge clk);
        downloading <= 1'b0;

        // All slots start together and GFX1 goes first
        req_addrs.delete();
        fork
            read_slot(0, da[0], lats[0]);
            read_slot(1, da[1], lats[1]);
            read_slot(2, da[2], lats[2]);
            read_slot(3, da[3], lats[3]);
        join
        if (req_addrs.size() != 4 || req_addrs[0] != word_of(0, da[0])) begin
            errors++;
            $display("FAIL %0t: concurrent reads made %0d requests, first at %h", $time,
                     req_addrs.size(), req_addrs.size() > 0 ? req_addrs[0] : '0);
        end

        repeat (4) @(posedge clk);
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0 && checks > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb_sdram_model.sv
/* Behavioral SDRAM for the testbench. Reads and writes share one ack.
   Ack and read data come after random delays of a few cycles.
   Unwritten words read back a fill pattern of their whole address */
`include "game_macros.svh"

module tb_sdram_model #(
    parameter int unsigned SEED = 32'h1
) (
    input                        clk,
    input                        rst_n,
    input                        sdram_req,
    input        [`SDRAM_AW-1:0] sdram_addr,
    input                        prog_we,
    input  sdram_pkg::prog_wr_t  prog,
    output logic                 sdram_ack,
    output logic                 data_rdy,
    output logic [15:0]          data_read
);

    localparam int MAX_ACK  = 3;        // Extra cycles before ack
    localparam int MAX_DATA = 4;        // Extra cycles from ack to data

    logic [15:0] mem [logic [`SDRAM_AW-1:0]];  // Downloaded words only

    function automatic logic [15:0] fill_word(input logic [`SDRAM_AW-1:0] a);
        return 16'(a * 22'h2f5b) ^ a[`SDRAM_AW-1:6];
    endfunction

    initial begin
        logic        is_wr;
        logic [15:0] w;
        void'($urandom(SEED));
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (rst_n && (sdram_req || prog_we)) begin
                is_wr = prog_we;
                repeat ($urandom_range(MAX_ACK)) @(posedge clk);
                sdram_ack <= 1'b1;
                if (is_wr) begin
                    w = mem.exists(prog.addr) ? mem[prog.addr] : fill_word(prog.addr);
                    if (!prog.mask[0]) w[7:0] = prog.data;   // Mask is active low
                    if (!prog.mask[1]) w[15:8] = prog.data;
                    mem[prog.addr] = w;
                end else begin
                    w = mem.exists(sdram_addr) ? mem[sdram_addr] : fill_word(sdram_addr);
                end
                @(posedge clk);
                sdram_ack <= 1'b0;
                if (!is_wr) begin
                    repeat ($urandom_range(MAX_DATA)) @(posedge clk);
                    data_read <= w;
                    data_rdy  <= 1'b1;
                    @(posedge clk);
                    data_rdy  <= 1'b0;
                end
            end
        end
    end

endmodule
